//--- source/soc_pkg.sv
`default_nettype none

package soc_pkg;

  //////////////////////////////////////////////////
  // Address map
  //////////////////////////////////////////////////

  localparam logic [31:0] uart_base_addr  = 32'h1000_0000;
  localparam logic [31:0] uart_top_addr   = 32'h1000_0010; // Exclusive
  localparam logic [31:0] timer_base_addr = 32'h0200_0000;
  localparam logic [31:0] timer_top_addr  = 32'h0200_0010; // Exclusive

  localparam int bram_depth  = 1024; // Every address outside the two windows aliases here
  localparam int bram_addr_w = $clog2(bram_depth);

  //////////////////////////////////////////////////
  // Register offsets
  //////////////////////////////////////////////////

  localparam logic [31:0] uart_data_off = 32'h0;
  localparam logic [31:0] uart_stat_off = 32'h4;

  localparam logic [31:0] timer_lo_off     = 32'h0;
  localparam logic [31:0] timer_hi_off     = 32'h4;
  localparam logic [31:0] timer_cmp_lo_off = 32'h8;
  localparam logic [31:0] timer_cmp_hi_off = 32'hC;

  // Timing of the UART and the timer, in clk_pll cycles
  localparam int clks_per_bit = 8;
  localparam int baud_cnt_w   = $clog2(clks_per_bit);
  localparam int timer_div    = 4;
  localparam int timer_div_w  = $clog2(timer_div);

endpackage

`default_nettype wire

//--- source/bus_decoder.sv
`timescale 1ns/1ps
`default_nettype none

module bus_decoder (
  input  wire logic        memory_valid,
  input  wire logic [31:0] memory_addr,
  input  wire logic [31:0] memory_wdata,
  input  wire logic [3:0]  memory_wstrb,
  input  wire logic [31:0] bram_rdata,
  input  wire logic        bram_ready,
  input  wire logic [31:0] uart_rdata,
  input  wire logic        uart_ready,
  input  wire logic [31:0] timer_rdata,
  input  wire logic        timer_ready,
  output logic      [31:0] memory_rdata,
  output logic             memory_ready,
  output logic             bram_valid,
  output logic             bram_wen,
  output logic             uart_valid,
  output logic      [31:0] uart_addr,
  output logic             timer_valid,
  output logic      [31:0] timer_addr
);

  // wdata and wstrb go to the targets straight from the master; only the
  // address range picks who sees valid
  always_comb begin
    bram_valid  = 1'b0;
    uart_valid  = 1'b0;
    timer_valid = 1'b0;
    if (memory_addr >= soc_pkg::uart_base_addr && memory_addr < soc_pkg::uart_top_addr) begin
      uart_valid = memory_valid;
    end else if (memory_addr >= soc_pkg::timer_base_addr &&
                 memory_addr < soc_pkg::timer_top_addr) begin
      timer_valid = memory_valid;
    end else begin
      bram_valid = memory_valid; // Default target
    end
  end

  assign bram_wen   = bram_valid & (|memory_wstrb);
  assign uart_addr  = memory_addr ^ soc_pkg::uart_base_addr;
  assign timer_addr = memory_addr ^ soc_pkg::timer_base_addr;

  always_comb begin
    if (bram_ready) begin
      memory_rdata = bram_rdata;
      memory_ready = 1'b1;
    end else if (uart_ready) begin
      memory_rdata = uart_rdata;
      memory_ready = 1'b1;
    end else if (timer_ready) begin
      memory_rdata = timer_rdata;
      memory_ready = 1'b1;
    end else begin
      memory_rdata = '0; // Idle bus reads as zero
      memory_ready = 1'b0;
    end
  end

endmodule

`default_nettype wire

//--- source/bram.sv
`timescale 1ns/1ps
`default_nettype none

module bram (
  input  wire logic        clk_pll,
  input  wire logic        reset,
  input  wire logic        bram_valid,
  input  wire logic        bram_wen,
  input  wire logic [31:0] memory_addr,
  input  wire logic [31:0] memory_wdata,
  input  wire logic [3:0]  memory_wstrb,
  output logic      [31:0] bram_rdata,
  output logic             bram_ready
);

  logic [31:0]                     mem [soc_pkg::bram_depth];
  logic [soc_pkg::bram_addr_w-1:0] idx;
  logic                            wr_en;

  assign idx   = memory_addr[soc_pkg::bram_addr_w+1:2]; // Upper address bits alias onto this
  assign wr_en = bram_wen & ~bram_ready; // Once per access, on the edge that raises ready

  always_ff @(posedge clk_pll) begin
    for (int i = 0; i < 4; i++) begin
      if (wr_en && memory_wstrb[i]) begin
        mem[idx][i*8 +: 8] <= memory_wdata[i*8 +: 8];
      end
    end
    bram_rdata <= mem[idx];
  end

  always_ff @(posedge clk_pll) begin
    if (reset) begin
      bram_ready <= 1'b0;
    end else begin
      bram_ready <= bram_valid & ~bram_ready; // Single-cycle pulse
    end
  end

endmodule

`default_nettype wire

//--- source/uart_tx.sv
`timescale 1ns/1ps
`default_nettype none

module uart_tx (
  input  wire logic       clk_pll,
  input  wire logic       reset,
  input  wire logic       tx_start,
  input  wire logic [7:0] tx_data,
  output logic            tx_busy,
  output logic            tx
);

  logic [soc_pkg::baud_cnt_w-1:0] baud_cnt;
  logic [3:0]                     bit_cnt; // 0 start, 1..8 data, 9 stop
  logic [8:0]                     shreg;   // Data bits, then the stop bit

  always_ff @(posedge clk_pll) begin
    if (reset) begin
      tx_busy  <= 1'b0;
      tx       <= 1'b1;
      baud_cnt <= '0;
      bit_cnt  <= '0;
      shreg    <= '1;
    end else if (!tx_busy) begin
      if (tx_start) begin
        tx_busy  <= 1'b1;
        tx       <= 1'b0; // Start bit
        baud_cnt <= '0;
        bit_cnt  <= '0;
        shreg    <= {1'b1, tx_data};
      end
    end else if (baud_cnt == soc_pkg::baud_cnt_w'(soc_pkg::clks_per_bit - 1)) begin
      baud_cnt <= '0;
      if (bit_cnt == 4'd9) begin
        tx_busy <= 1'b0; // Stop bit done, line already high
      end else begin
        tx      <= shreg[0];
        shreg   <= {1'b1, shreg[8:1]};
        bit_cnt <= bit_cnt + 4'd1;
      end
    end else begin
      baud_cnt <= baud_cnt + 1'b1;
    end
  end

endmodule

`default_nettype wire

//--- source/uart_rx.sv
`timescale 1ns/1ps
`default_nettype none

module uart_rx (
  input  wire logic       clk_pll,
  input  wire logic       reset,
  input  wire logic       rx,
  output logic      [7:0] rx_data,
  output logic            rx_strobe
);

  logic [2:0]                     rx_sync; // Two sync stages plus one for edge detect
  logic                           rx_s;
  logic                           active;
  logic [3:0]                     bit_cnt; // 0 start, 1..8 data, 9 stop
  logic [soc_pkg::baud_cnt_w-1:0] baud_cnt;
  logic [soc_pkg::baud_cnt_w-1:0] baud_last;

  assign rx_s = rx_sync[1];

  // The start bit is checked at half a bit, so later samples land mid-bit
  assign baud_last = (bit_cnt == 4'd0) ?
                     soc_pkg::baud_cnt_w'(soc_pkg::clks_per_bit / 2 - 1) :
                     soc_pkg::baud_cnt_w'(soc_pkg::clks_per_bit - 1);

  always_ff @(posedge clk_pll) begin
    if (reset) begin
      rx_sync   <= '1;
      active    <= 1'b0;
      bit_cnt   <= '0;
      baud_cnt  <= '0;
      rx_strobe <= 1'b0;
    end else begin
      rx_sync   <= {rx_sync[1:0], rx};
      rx_strobe <= 1'b0;
      if (!active) begin
        if (rx_sync[2] && !rx_sync[1]) begin
          active   <= 1'b1; // Falling edge of a start bit
          bit_cnt  <= '0;
          baud_cnt <= '0;
        end
      end else if (baud_cnt == baud_last) begin
        baud_cnt <= '0;
        bit_cnt  <= bit_cnt + 4'd1;
        if (bit_cnt == 4'd0 && rx_s) begin
          active <= 1'b0; // Glitch, not a start bit
        end else if (bit_cnt == 4'd9) begin
          active    <= 1'b0;
          rx_strobe <= rx_s; // Framing error drops the byte
        end
      end else begin
        baud_cnt <= baud_cnt + 1'b1;
      end
    end
  end

  always_ff @(posedge clk_pll) begin
    if (active && baud_cnt == baud_last && bit_cnt >= 4'd1 && bit_cnt <= 4'd8) begin
      rx_data <= {rx_s, rx_data[7:1]}; // LSB arrives first
    end
  end

endmodule

`default_nettype wire

//--- source/uart.sv
`timescale 1ns/1ps
`default_nettype none

module uart (
  input  wire logic        clk_pll,
  input  wire logic        reset,
  input  wire logic        uart_valid,
  input  wire logic [31:0] uart_addr,
  input  wire logic [31:0] memory_wdata,
  input  wire logic [3:0]  memory_wstrb,
  input  wire logic        rx,
  output logic      [31:0] uart_rdata,
  output logic             uart_ready,
  output logic             tx
);

  logic       access;
  logic       is_write;
  logic       tx_start;
  logic       tx_busy;
  logic [7:0] rx_data;
  logic       rx_strobe;
  logic [7:0] rx_byte;
  logic       rx_valid;

  assign access   = uart_valid & ~uart_ready;
  assign is_write = |memory_wstrb;
  assign tx_start = access & is_write & (uart_addr == soc_pkg::uart_data_off);

  always_ff @(posedge clk_pll) begin
    if (reset) begin
      uart_ready <= 1'b0;
      rx_valid   <= 1'b0;
    end else begin
      uart_ready <= access;
      if (rx_strobe) begin
        rx_valid <= 1'b1; // A fresh byte beats a read in the same cycle
      end else if (access && !is_write && uart_addr == soc_pkg::uart_data_off) begin
        rx_valid <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk_pll) begin
    if (rx_strobe) begin
      rx_byte <= rx_data; // Overwrites an unread byte
    end
    if (access) begin
      case (uart_addr)
        soc_pkg::uart_data_off: uart_rdata <= {24'b0, rx_byte};
        soc_pkg::uart_stat_off: uart_rdata <= {30'b0, rx_valid, tx_busy};
        default:                uart_rdata <= '0;
      endcase
    end
  end

  uart_tx u_uart_tx (
    .clk_pll  (clk_pll),
    .reset    (reset),
    .tx_start (tx_start),
    .tx_data  (memory_wdata[7:0]),
    .tx_busy  (tx_busy),
    .tx       (tx)
  );

  uart_rx u_uart_rx (
    .clk_pll   (clk_pll),
    .reset     (reset),
    .rx        (rx),
    .rx_data   (rx_data),
    .rx_strobe (rx_strobe)
  );

endmodule

`default_nettype wire

//--- source/timer.sv
`timescale 1ns/1ps
`default_nettype none

module timer (
  input  wire logic        clk_pll,
  input  wire logic        reset,
  input  wire logic        timer_valid,
  input  wire logic [31:0] timer_addr,
  input  wire logic [31:0] memory_wdata,
  input  wire logic [3:0]  memory_wstrb,
  output logic      [31:0] timer_rdata,
  output logic             timer_ready,
  output logic             timer_irpt
);

  logic [soc_pkg::timer_div_w-1:0] presc;
  logic                            tick;
  logic [63:0]                     mtime;
  logic [63:0]                     mtimecmp;
  logic                            access;
  logic                            wr;

  function automatic logic [31:0] merge_strb(input logic [31:0] old_word,
                                             input logic [31:0] new_word,
                                             input logic [3:0]  strb);
    logic [31:0] res;
    res = old_word;
    for (int i = 0; i < 4; i++) begin
      if (strb[i]) begin
        res[i*8 +: 8] = new_word[i*8 +: 8];
      end
    end
    return res;
  endfunction

  assign tick   = (presc == soc_pkg::timer_div_w'(soc_pkg::timer_div - 1));
  assign access = timer_valid & ~timer_ready;
  assign wr     = access & (|memory_wstrb);

  //////////////////////////////////////////////////
  // Counter, compare and interrupt
  //////////////////////////////////////////////////

  always_ff @(posedge clk_pll) begin
    if (reset) begin
      presc       <= '0;
      mtime       <= '0;
      mtimecmp    <= '1; // Interrupt stays off until software sets a compare
      timer_irpt  <= 1'b0;
      timer_ready <= 1'b0;
    end else begin
      timer_ready <= access;
      timer_irpt  <= (mtime >= mtimecmp);
      presc       <= tick ? '0 : presc + 1'b1;
      if (wr && timer_addr == soc_pkg::timer_lo_off) begin
        mtime[31:0] <= merge_strb(mtime[31:0], memory_wdata, memory_wstrb);
      end else if (wr && timer_addr == soc_pkg::timer_hi_off) begin
        mtime[63:32] <= merge_strb(mtime[63:32], memory_wdata, memory_wstrb);
      end else if (tick) begin
        mtime <= mtime + 64'd1;
      end
      if (wr && timer_addr == soc_pkg::timer_cmp_lo_off) begin
        mtimecmp[31:0] <= merge_strb(mtimecmp[31:0], memory_wdata, memory_wstrb);
      end
      if (wr && timer_addr == soc_pkg::timer_cmp_hi_off) begin
        mtimecmp[63:32] <= merge_strb(mtimecmp[63:32], memory_wdata, memory_wstrb);
      end
    end
  end

  always_ff @(posedge clk_pll) begin
    if (access) begin
      case (timer_addr)
        soc_pkg::timer_lo_off:     timer_rdata <= mtime[31:0];
        soc_pkg::timer_hi_off:     timer_rdata <= mtime[63:32];
        soc_pkg::timer_cmp_lo_off: timer_rdata <= mtimecmp[31:0];
        soc_pkg::timer_cmp_hi_off: timer_rdata <= mtimecmp[63:32];
        default:                   timer_rdata <= '0; // Unmapped offset
      endcase
    end
  end

endmodule

`default_nettype wire

//--- source/soc_top.sv
`timescale 1ns/1ps
`default_nettype none

module soc_top (
  input  wire logic        clk_pll,
  input  wire logic        reset,
  input  wire logic        memory_valid,
  input  wire logic [31:0] memory_addr,
  input  wire logic [31:0] memory_wdata,
  input  wire logic [3:0]  memory_wstrb,
  input  wire logic        rx,
  output logic      [31:0] memory_rdata,
  output logic             memory_ready,
  output logic             tx,
  output logic             timer_irpt
);

  logic        bram_valid;
  logic        bram_wen;
  logic [31:0] bram_rdata;
  logic        bram_ready;
  logic        uart_valid;
  logic [31:0] uart_addr;
  logic [31:0] uart_rdata;
  logic        uart_ready;
  logic        timer_valid;
  logic [31:0] timer_addr;
  logic [31:0] timer_rdata;
  logic        timer_ready;

  bus_decoder u_bus_decoder (
    .memory_valid (memory_valid),
    .memory_addr  (memory_addr),
    .memory_wdata (memory_wdata),
    .memory_wstrb (memory_wstrb),
    .bram_rdata   (bram_rdata),
    .bram_ready   (bram_ready),
    .uart_rdata   (uart_rdata),
    .uart_ready   (uart_ready),
    .timer_rdata  (timer_rdata),
    .timer_ready  (timer_ready),
    .memory_rdata (memory_rdata),
    .memory_ready (memory_ready),
    .bram_valid   (bram_valid),
    .bram_wen     (bram_wen),
    .uart_valid   (uart_valid),
    .uart_addr    (uart_addr),
    .timer_valid  (timer_valid),
    .timer_addr   (timer_addr)
  );

  bram u_bram (
    .clk_pll      (clk_pll),
    .reset        (reset),
    .bram_valid   (bram_valid),
    .bram_wen     (bram_wen),
    .memory_addr  (memory_addr),
    .memory_wdata (memory_wdata),
    .memory_wstrb (memory_wstrb),
    .bram_rdata   (bram_rdata),
    .bram_ready   (bram_ready)
  );

  uart u_uart (
    .clk_pll      (clk_pll),
    .reset        (reset),
    .uart_valid   (uart_valid),
    .uart_addr    (uart_addr),
    .memory_wdata (memory_wdata),
    .memory_wstrb (memory_wstrb),
    .rx           (rx),
    .uart_rdata   (uart_rdata),
    .uart_ready   (uart_ready),
    .tx           (tx)
  );

  timer u_timer (
    .clk_pll      (clk_pll),
    .reset        (reset),
    .timer_valid  (timer_valid),
    .timer_addr   (timer_addr),
    .memory_wdata (memory_wdata),
    .memory_wstrb (memory_wstrb),
    .timer_rdata  (timer_rdata),
    .timer_ready  (timer_ready),
    .timer_irpt   (timer_irpt)
  );

endmodule

`default_nettype wire

//--- dv/soc_tb.sv
`timescale 1ns/1ps
`default_nettype none

module soc_tb #(
  parameter int seed_init = 62
);

  localparam int n_ram       = 24;
  localparam int access_clks = 3; // Idle cycle, request cycle, ready cycle
  localparam int frame_clks  = 10 * soc_pkg::clks_per_bit;
  // RAM passes plus UART, timer and decode accesses, two frames, timer waits
  localparam int test_clks   = 10 + (4 * n_ram + 60) * access_clks + 2 * frame_clks + 80;
  localparam int limit_ns    = 2 * test_clks * 20;

  localparam logic [31:0] uart_data = soc_pkg::uart_base_addr + soc_pkg::uart_data_off;
  localparam logic [31:0] uart_stat = soc_pkg::uart_base_addr + soc_pkg::uart_stat_off;
  localparam logic [31:0] mtime_lo  = soc_pkg::timer_base_addr + soc_pkg::timer_lo_off;
  localparam logic [31:0] cmp_lo    = soc_pkg::timer_base_addr + soc_pkg::timer_cmp_lo_off;
  localparam logic [31:0] cmp_hi    = soc_pkg::timer_base_addr + soc_pkg::timer_cmp_hi_off;

  logic        clk_pll = 1'b0;
  logic        reset;
  logic        memory_valid;
  logic [31:0] memory_addr;
  logic [31:0] memory_wdata;
  logic [3:0]  memory_wstrb;
  logic        loop_en;
  logic        rx;
  logic [31:0] memory_rdata;
  logic        memory_ready;
  logic        tx;
  logic        timer_irpt;

  integer      seed = seed_init;
  int          cycle = 0;
  int          ready_cycle;
  int          chk_errors = 0;
  int          cmp_errors = 0;

  // Reference model state
  logic [31:0] shadow_ram [soc_pkg::bram_depth];
  logic [63:0] exp_cmp = '1;
  logic        exp_tx_busy = 1'b0;
  logic        exp_rx_valid = 1'b0;
  logic [7:0]  exp_rx_byte;

  event        read_done;
  string       cmp_name;
  logic [31:0] cmp_exp;
  logic [31:0] cmp_act;

  int          start_cnt = 0;
  int          frame_cnt = 0;
  logic [7:0]  frame_byte [4];
  logic        frame_good [4];

  assign rx = loop_en ? tx : 1'b1; // tx loops back once reset is over

  soc_top u_dut (
    .clk_pll      (clk_pll),
    .reset        (reset),
    .memory_valid (memory_valid),
    .memory_addr  (memory_addr),
    .memory_wdata (memory_wdata),
    .memory_wstrb (memory_wstrb),
    .rx           (rx),
    .memory_rdata (memory_rdata),
    .memory_ready (memory_ready),
    .tx           (tx),
    .timer_irpt   (timer_irpt)
  );

  always #10 clk_pll = ~clk_pll;

  always @(posedge clk_pll) begin
    cycle <= cycle + 1;
  end

  //////////////////////////////////////////////////
  // Reference model
  //////////////////////////////////////////////////

  function automatic logic in_uart(input logic [31:0] addr);
    return addr >= soc_pkg::uart_base_addr && addr < soc_pkg::uart_top_addr;
  endfunction

  function automatic logic in_timer(input logic [31:0] addr);
    return addr >= soc_pkg::timer_base_addr && addr < soc_pkg::timer_top_addr;
  endfunction

  function automatic logic [31:0] ram_addr(input logic [31:0] addr);
    logic [31:0] a;
    a = {addr[31:2], 2'b00};
    if (in_uart(a) || in_timer(a)) begin
      a = a ^ 32'h8000_0000; // Moves it out of both windows onto the same RAM word
    end
    return a;
  endfunction

  function automatic logic [31:0] merge_lanes(input logic [31:0] old_word,
                                              input logic [31:0] new_word,
                                              input logic [3:0]  strb);
    logic [31:0] res;
    res = old_word;
    for (int i = 0; i < 4; i++) begin
      if (strb[i]) begin
        res[i*8 +: 8] = new_word[i*8 +: 8];
      end
    end
    return res;
  endfunction

  function automatic logic [31:0] expected_read(input logic [31:0] addr);
    logic [31:0] rd;
    if (in_uart(addr)) begin
      case (addr ^ soc_pkg::uart_base_addr)
        soc_pkg::uart_data_off: rd = {24'b0, exp_rx_byte};
        soc_pkg::uart_stat_off: rd = {30'b0, exp_rx_valid, exp_tx_busy};
        default:                rd = '0;
      endcase
    end else if (in_timer(addr)) begin
      case (addr ^ soc_pkg::timer_base_addr)
        soc_pkg::timer_cmp_lo_off: rd = exp_cmp[31:0];
        soc_pkg::timer_cmp_hi_off: rd = exp_cmp[63:32];
        default:                   rd = '0; // mtime is checked by its rate instead
      endcase
    end else begin
      rd = shadow_ram[addr[2 +: soc_pkg::bram_addr_w]];
    end
    return rd;
  endfunction

  task automatic model_write(input logic [31:0] addr, input logic [31:0] wdata,
                             input logic [3:0] wstrb);
    if (in_uart(addr)) begin
      if (addr == uart_data && !exp_tx_busy) begin
        exp_tx_busy = 1'b1; // A write while busy is dropped
      end
    end else if (in_timer(addr)) begin
      if (addr == cmp_lo) begin
        exp_cmp[31:0] = merge_lanes(exp_cmp[31:0], wdata, wstrb);
      end else if (addr == cmp_hi) begin
        exp_cmp[63:32] = merge_lanes(exp_cmp[63:32], wdata, wstrb);
      end
    end else begin
      shadow_ram[addr[2 +: soc_pkg::bram_addr_w]] =
        merge_lanes(shadow_ram[addr[2 +: soc_pkg::bram_addr_w]], wdata, wstrb);
    end
  endtask

  //////////////////////////////////////////////////
  // Bus master
  //////////////////////////////////////////////////

  task automatic bus_access(input logic [31:0] addr, input logic [31:0] wdata,
                            input logic [3:0] wstrb, input string name,
                            output logic [31:0] rdata);
    int waited;
    @(negedge clk_pll);
    assert (memory_ready === 1'b0) else begin
      chk_errors++;
      $display("Ready was high with no request pending before %s", name);
    end
    memory_valid = 1'b1;
    memory_addr  = addr;
    memory_wdata = wdata;
    memory_wstrb = wstrb;
    waited = 0;
    do begin
      @(negedge clk_pll);
      waited++;
    end while (memory_ready !== 1'b1 && waited < 16);
    assert (memory_ready === 1'b1) else begin
      chk_errors++;
      $display("No ready from the bus for %s within 16 cycles", name);
    end
    assert (waited == 1) else begin
      chk_errors++;
      $display("Error: %s latency expected 1 actual %0d", name, waited);
    end
    rdata        = memory_rdata;
    ready_cycle  = cycle;
    memory_valid = 1'b0;
    memory_wstrb = 4'h0;
  endtask

  task automatic write_word(input logic [31:0] addr, input logic [31:0] wdata,
                            input logic [3:0] wstrb, input string name);
    logic [31:0] unused;
    bus_access(addr, wdata, wstrb, name, unused);
    model_write(addr, wdata, wstrb);
  endtask

  task automatic read_check(input logic [31:0] addr, input string name);
    logic [31:0] act;
    bus_access(addr, 32'h0, 4'h0, name, act);
    cmp_exp  = expected_read(addr);
    cmp_act  = act;
    cmp_name = name;
    -> read_done;
    if (addr == uart_data) begin
      exp_rx_valid = 1'b0; // Reading the data register consumes the byte
    end
  endtask

  always @(read_done) begin
    assert (cmp_act === cmp_exp) else begin
      cmp_errors++;
      $display("Error: %s expected %08h actual %08h", cmp_name, cmp_exp, cmp_act);
    end
  end

  // Rebuilds 8N1 frames from tx, sampling near mid-bit
  initial begin : tx_monitor
    logic       prev;
    logic       start_bit;
    logic [7:0] data;
    prev = 1'b1;
    forever begin
      @(negedge clk_pll);
      if (!reset && prev === 1'b1 && tx === 1'b0) begin
        start_cnt++;
        repeat (soc_pkg::clks_per_bit / 2 - 1) @(negedge clk_pll);
        start_bit = tx;
        for (int i = 0; i < 8; i++) begin
          repeat (soc_pkg::clks_per_bit) @(negedge clk_pll);
          data[i] = tx;
        end
        repeat (soc_pkg::clks_per_bit) @(negedge clk_pll);
        if (frame_cnt < 4) begin
          frame_byte[frame_cnt] = data;
          frame_good[frame_cnt] = !start_bit && tx;
        end
        frame_cnt++;
      end
      prev = tx;
    end
  end

  //////////////////////////////////////////////////
  // Tests
  //////////////////////////////////////////////////

  task automatic ram_test();
    logic [31:0] addrs [n_ram];
    logic [31:0] rnd;
    logic [31:0] data;
    logic [3:0]  strb;
    for (int i = 0; i < n_ram; i++) begin
      rnd      = $random(seed);
      addrs[i] = ram_addr(rnd);
      data     = $random(seed);
      write_word(addrs[i], data, 4'hF, "ram full write");
    end
    for (int i = 0; i < n_ram; i++) begin
      rnd = $random(seed);
      read_check(ram_addr(addrs[i] ^ {rnd[31:12], 12'h0}), "ram alias read");
    end
    for (int i = 0; i < n_ram; i++) begin
      rnd  = $random(seed);
      strb = (rnd[3:0] == 4'h0) ? 4'h5 : rnd[3:0];
      data = $random(seed);
      write_word(addrs[i], data, strb, "ram partial write");
      read_check(addrs[i], "ram partial read");
    end
  endtask

  task automatic uart_test();
    logic [31:0] rnd;
    logic [31:0] d;
    logic [7:0]  first;
    int          waited;
    int          polls;
    rnd   = $random(seed);
    first = rnd[7:0];
    write_word(uart_data, {24'b0, first}, 4'h1, "uart tx write");
    read_check(uart_stat, "uart status busy");
    write_word(uart_data, {24'b0, ~first}, 4'h1, "uart write while busy");
    waited = 0;
    while (frame_cnt < 1 && waited < 2 * frame_clks) begin
      @(negedge clk_pll);
      waited++;
    end
    assert (frame_cnt == 1) else begin
      chk_errors++;
      $display("No complete UART frame appeared on tx");
    end
    if (frame_cnt >= 1) begin
      assert (frame_good[0] && frame_byte[0] === first) else begin
        chk_errors++;
        $display("Error: uart tx frame expected 1/%02h actual %0d/%02h",
                 first, frame_good[0], frame_byte[0]);
      end
    end
    polls = 0;
    do begin
      bus_access(uart_stat, 32'h0, 4'h0, "uart status poll", d);
      polls++;
    end while (!d[1] && polls < 4 * soc_pkg::clks_per_bit);
    assert (d[1]) else begin
      chk_errors++;
      $display("UART receiver never flagged the looped-back byte");
    end
    exp_tx_busy  = 1'b0;
    exp_rx_valid = 1'b1;
    exp_rx_byte  = first;
    read_check(uart_stat, "uart status rx_valid");
    read_check(uart_data, "uart rx data");
    read_check(uart_stat, "uart status cleared");
    repeat (2 * soc_pkg::clks_per_bit) @(negedge clk_pll);
    assert (start_cnt == 1) else begin
      chk_errors++;
      $display("Error: uart frames started expected 1 actual %0d", start_cnt);
    end
  endtask

  task automatic check_irpt(input logic level, input string name);
    int waited;
    waited = 0;
    do begin
      @(negedge clk_pll);
      waited++;
    end while (timer_irpt !== level && waited < 2);
    assert (timer_irpt === level) else begin
      chk_errors++;
      $display("Error: %s expected %0d actual %0d", name, level, timer_irpt);
    end
  endtask

  task automatic timer_test();
    logic [31:0] t0;
    logic [31:0] t1;
    logic [31:0] diff;
    int          c0;
    int          n;
    bus_access(mtime_lo, 32'h0, 4'h0, "mtime first read", t0);
    c0 = ready_cycle;
    repeat (37) @(negedge clk_pll);
    bus_access(mtime_lo, 32'h0, 4'h0, "mtime second read", t1);
    n    = ready_cycle - c0;
    diff = t1 - t0;
    assert (diff == n / soc_pkg::timer_div ||
            diff == (n + soc_pkg::timer_div - 1) / soc_pkg::timer_div) else begin
      chk_errors++;
      $display("Error: mtime rate expected %0d actual %0d", n / soc_pkg::timer_div, diff);
    end
    read_check(cmp_lo, "mtimecmp low reset");
    read_check(cmp_hi, "mtimecmp high reset");
    for (int i = 0; i < 20; i++) begin
      @(negedge clk_pll);
      assert (timer_irpt === 1'b0) else begin
        chk_errors++;
        $display("Timer interrupt rose with mtimecmp at its reset value");
      end
    end
    write_word(cmp_lo, 32'h0, 4'hF, "mtimecmp low clear");
    check_irpt(1'b0, "irpt after low clear");
    write_word(cmp_hi, 32'h0, 4'hF, "mtimecmp high clear");
    check_irpt(1'b1, "irpt after compare cleared");
    read_check(cmp_lo, "mtimecmp low readback");
    read_check(cmp_hi, "mtimecmp high readback");
    write_word(cmp_hi, 32'hFFFF_FFFF, 4'hF, "mtimecmp high set");
    check_irpt(1'b0, "irpt after high set");
    read_check(cmp_hi, "mtimecmp high set readback");
  endtask

  task automatic decode_test();
    logic [31:0] rnd;
    rnd = $random(seed);
    write_word(32'h0000_0004, rnd, 4'hF, "ram word 1 write");
    write_word(32'h0000_0008, ~rnd, 4'hF, "ram word 2 write");
    write_word(uart_stat, ~rnd, 4'hF, "uart status write");
    write_word(cmp_lo, rnd, 4'hF, "mtimecmp low write");
    read_check(32'h0000_0004, "ram word 1 after window writes");
    read_check(32'h1000_1004, "ram word 1 alias");
    read_check(32'h0200_1008, "ram word 2 alias");
    read_check(soc_pkg::timer_base_addr + 32'h2, "timer unmapped offset");
    read_check(cmp_lo, "mtimecmp low decode readback");
  endtask

  initial begin
    reset        = 1'b1;
    loop_en      = 1'b0;
    memory_valid = 1'b0;
    memory_addr  = 32'h0;
    memory_wdata = 32'h0;
    memory_wstrb = 4'h0;
    repeat (10) @(negedge clk_pll);
    reset   = 1'b0;
    loop_en = 1'b1;
    @(negedge clk_pll);
    assert (memory_ready === 1'b0 && tx === 1'b1 && timer_irpt === 1'b0) else begin
      chk_errors++;
      $display("Bus, UART or timer outputs were not idle after reset");
    end
    ram_test();
    uart_test();
    timer_test();
    decode_test();
    repeat (4) @(negedge clk_pll);
    $display("Errors: %0d in read compares, %0d in other checks", cmp_errors, chk_errors);
    if (cmp_errors + chk_errors == 0) begin
      $display("TEST PASSED");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

  initial begin
    #(limit_ns);
    $display("Watchdog expired after %0d ns, the run hung", limit_ns);
    $display("TEST FAILED");
    $finish;
  end

endmodule

`default_nettype wire

//--- files.f
source/soc_pkg.sv
source/bus_decoder.sv
source/bram.sv
source/uart_tx.sv
source/uart_rx.sv
source/uart.sv
source/timer.sv
source/soc_top.sv
dv/soc_tb.sv

//--- Makefile
VERILATOR ?= verilator
TOP       ?= soc_tb
SEED      ?= 62
LOG       ?= sim.log
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert --timescale 1ns/1ps

SRCS := $(wildcard source/*.sv dv/*.sv)
BIN  := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: run

$(BIN): files.f $(SRCS)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Gseed_init=$(SEED) --Mdir $(OBJ_DIR) -f files.f

run: $(BIN)
	./$(BIN) > $(LOG) 2>&1; cat $(LOG)
	@grep -q "TEST PASSED" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
